//--- Makefile
# Verilator build for the PCIe TLP handler

OBJ_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module pcie_tlp_handler

sim:
	verilator --binary --timing --assert -f project.f --top-module tb_pcie_tlp_handler \
		--Mdir $(OBJ_DIR) -o sim_tb
	-./$(OBJ_DIR)/sim_tb | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

//--- design/cpl_instant_sender.sv
`timescale 1ns/1ps
`include "tlp_consts.svh"

module cpl_instant_sender (
  input  logic                 clk,
  input  logic                 reset,
  input  tlp_pkg::pcie_id_t    my_id,
  input  logic                 frm_end,
  input  logic                 frm_is_npr,
  input  logic                 frm_unsupported,
  input  tlp_pkg::tlp_kind_e   frm_kind,
  input  tlp_pkg::pcie_id_t    frm_requester_id,
  input  tlp_pkg::tag_t        frm_tag,
  input  tlp_pkg::byte_count_t frm_byte_count,
  input  tlp_pkg::lower_addr_t frm_lower_addr,
  output tlp_pkg::tlp_beat_t   tx_data,
  output tlp_pkg::tlp_empty_t  tx_empty,
  output logic                 tx_sop,
  output logic                 tx_eop,
  output logic                 tx_valid
);
  import tlp_pkg::*;

  dword_t [0:7] dw;
  logic         zero_len_rd;
  logic         send;

  // Supported read with an invalid BE pattern, completed without data
  assign zero_len_rd = (frm_kind == TLP_MRD) && (frm_byte_count == 12'd0);
  assign send        = frm_end && frm_is_npr && (frm_unsupported || zero_len_rd);

  always_comb begin
    dw = '0;
    dw[0][31:29] = frm_unsupported ? `FMT_CPL : `FMT_CPLD;
    dw[0][28:24] = `TYPE_CPL;
    dw[0][9:0]   = 10'd0;                // No payload in either case
    dw[1][31:16] = my_id;                // Completer ID
    dw[1][15:13] = frm_unsupported ? `CPL_STATUS_UR : `CPL_STATUS_SC;
    dw[1][11:0]  = frm_unsupported ? frm_byte_count : 12'd0;
    dw[2][31:16] = frm_requester_id;
    dw[2][15:8]  = frm_tag;
    dw[2][6:0]   = frm_lower_addr;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_valid <= 1'b0;
      tx_sop   <= 1'b0;
      tx_eop   <= 1'b0;
    end else begin
      tx_valid <= send;  // Sink has ready latency zero
      tx_sop   <= send;
      tx_eop   <= send;
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      tx_data  <= dw;
      tx_empty <= `EMPTY_3DW_HDR;  // 3-DW header only
    end
  end

  a_single_beat: assert property (@(posedge clk) disable iff (reset)
    tx_valid |-> tx_sop && tx_eop && $past(frm_is_npr));

endmodule

//--- design/cpl_response_sender.sv
`timescale 1ns/1ps
`include "tlp_consts.svh"

module cpl_response_sender (
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  input  tlp_pkg::pcie_id_t   my_id,
  input  tlp_pkg::mem_resp_t  resp_data,
  input  logic                resp_valid,
  output tlp_pkg::tlp_beat_t  tx_data,
  output tlp_pkg::tlp_empty_t tx_empty,
  output logic                tx_sop,
  output logic                tx_eop,
  output logic                tx_valid
);
  import tlp_pkg::*;

  pcie_id_t     resp_requester_id;
  tag_t         resp_tag;
  lower_addr_t  resp_lower_addr;
  dword_t       resp_rddata;
  dword_t [0:7] dw;
  logic         send;

  // Response word fields
  assign resp_requester_id = resp_data[15:0];
  assign resp_tag          = resp_data[23:16];
  assign resp_lower_addr   = {resp_data[28:24], 2'b00};  // Dword aligned
  assign resp_rddata       = resp_data[63:32];
  assign send              = enable && resp_valid;

  always_comb begin
    dw = '0;
    dw[0][31:29] = `FMT_CPLD;
    dw[0][28:24] = `TYPE_CPL;
    dw[0][9:0]   = 10'd1;           // One dword of data
    dw[1][31:16] = my_id;
    dw[1][15:13] = `CPL_STATUS_SC;
    dw[1][11:0]  = 12'd4;
    dw[2][31:16] = resp_requester_id;
    dw[2][15:8]  = resp_tag;
    dw[2][6:0]   = resp_lower_addr;
    // Qword aligned address pads the header to dword 4
    if (resp_lower_addr[2])
      dw[3] = resp_rddata;
    else
      dw[4] = resp_rddata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_valid <= 1'b0;
      tx_sop   <= 1'b0;
      tx_eop   <= 1'b0;
    end else begin
      tx_valid <= send;
      tx_sop   <= send;
      tx_eop   <= send;
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      tx_data  <= dw;
      tx_empty <= resp_lower_addr[2] ? `EMPTY_DATA_DW3 : `EMPTY_DATA_DW4;
    end
  end

  a_single_beat: assert property (@(posedge clk) disable iff (reset)
    tx_valid |-> tx_sop && tx_eop && $past(resp_valid));

endmodule

//--- design/pcie_tlp_handler.sv
`timescale 1ns/1ps
`include "tlp_consts.svh"

module pcie_tlp_handler (
  input  logic                 clk,
  input  logic                 reset,
  input  tlp_pkg::tlp_beat_t   tlp_rx_st_data,
  input  tlp_pkg::tlp_empty_t  tlp_rx_st_empty,
  input  logic                 tlp_rx_st_startofpacket,
  input  logic                 tlp_rx_st_endofpacket,
  input  logic                 tlp_rx_st_valid,
  output logic                 tlp_rx_st_ready,
  input  tlp_pkg::pcie_id_t    my_id,
  input  logic                 my_id_valid,
  input  tlp_pkg::mem_resp_t   mem_access_resp_data,
  input  logic                 mem_access_resp_valid,
  output logic                 mem_access_resp_ready,
  output tlp_pkg::mem_req_t    mem_access_req_data,
  output logic                 mem_access_req_valid,
  output tlp_pkg::tlp_beat_t   tlp_tx_instant_st_data,
  output tlp_pkg::tlp_empty_t  tlp_tx_instant_st_empty,
  output logic                 tlp_tx_instant_st_startofpacket,
  output logic                 tlp_tx_instant_st_endofpacket,
  output logic                 tlp_tx_instant_st_valid,
  output tlp_pkg::tlp_beat_t   tlp_tx_response_st_data,
  output tlp_pkg::tlp_empty_t  tlp_tx_response_st_empty,
  output logic                 tlp_tx_response_st_startofpacket,
  output logic                 tlp_tx_response_st_endofpacket,
  output logic                 tlp_tx_response_st_valid,
  output logic [6:0]           cpl_err
);
  import tlp_pkg::*;

  logic        frm_end;
  logic        frm_is_npr;
  logic        frm_unsupported;
  tlp_kind_e   frm_kind;
  pcie_id_t    frm_requester_id;
  tag_t        frm_tag;
  byte_count_t frm_byte_count;
  lower_addr_t frm_lower_addr;
  logic        cpl_err_ur_np;
  logic        cpl_err_ur_p;

  // Work only once the completer ID is known
  assign tlp_rx_st_ready       = my_id_valid;
  assign mem_access_resp_ready = my_id_valid;

  // Bit 5 UR non-posted, bit 4 UR posted
  assign cpl_err = {1'b0, cpl_err_ur_np, cpl_err_ur_p, 4'b0000};

  tlp_rx_decoder decoder_i (
    .clk              (clk),
    .reset            (reset),
    .enable           (my_id_valid),
    .rx_data          (tlp_rx_st_data),
    .rx_sop           (tlp_rx_st_startofpacket),
    .rx_eop           (tlp_rx_st_endofpacket),
    .rx_valid         (tlp_rx_st_valid),
    .frm_end          (frm_end),
    .frm_is_npr       (frm_is_npr),
    .frm_unsupported  (frm_unsupported),
    .frm_kind         (frm_kind),
    .frm_requester_id (frm_requester_id),
    .frm_tag          (frm_tag),
    .frm_byte_count   (frm_byte_count),
    .frm_lower_addr   (frm_lower_addr),
    .cpl_err_ur_np    (cpl_err_ur_np),
    .cpl_err_ur_p     (cpl_err_ur_p),
    .mem_req_data     (mem_access_req_data),
    .mem_req_valid    (mem_access_req_valid)
  );

  cpl_instant_sender instant_i (
    .clk              (clk),
    .reset            (reset),
    .my_id            (my_id),
    .frm_end          (frm_end),
    .frm_is_npr       (frm_is_npr),
    .frm_unsupported  (frm_unsupported),
    .frm_kind         (frm_kind),
    .frm_requester_id (frm_requester_id),
    .frm_tag          (frm_tag),
    .frm_byte_count   (frm_byte_count),
    .frm_lower_addr   (frm_lower_addr),
    .tx_data          (tlp_tx_instant_st_data),
    .tx_empty         (tlp_tx_instant_st_empty),
    .tx_sop           (tlp_tx_instant_st_startofpacket),
    .tx_eop           (tlp_tx_instant_st_endofpacket),
    .tx_valid         (tlp_tx_instant_st_valid)
  );

  cpl_response_sender response_i (
    .clk        (clk),
    .reset      (reset),
    .enable     (my_id_valid),
    .my_id      (my_id),
    .resp_data  (mem_access_resp_data),
    .resp_valid (mem_access_resp_valid),
    .tx_data    (tlp_tx_response_st_data),
    .tx_empty   (tlp_tx_response_st_empty),
    .tx_sop     (tlp_tx_response_st_startofpacket),
    .tx_eop     (tlp_tx_response_st_endofpacket),
    .tx_valid   (tlp_tx_response_st_valid)
  );

  // Every accepted beat is a whole TLP with at least a 3-DW header
  a_rx_single_beat: assert property (@(posedge clk) disable iff (reset)
    tlp_rx_st_valid && tlp_rx_st_ready && tlp_rx_st_startofpacket |->
      tlp_rx_st_endofpacket && tlp_rx_st_empty <= `EMPTY_3DW_HDR);

endmodule

//--- design/tlp_byte_count.sv
`timescale 1ns/1ps

module tlp_byte_count (
  input  logic [3:0]           first_be,
  input  logic [3:0]           last_be,
  input  tlp_pkg::tlp_len_t    len,
  output tlp_pkg::byte_count_t byte_count
);
  import tlp_pkg::*;

  byte_count_t len_bytes;

  assign len_bytes = {len, 2'b00};  // Length in bytes, before trimming

  // Byte count from Length and byte enables, PCIe base spec table
  always_comb begin
    casez ({first_be, last_be})
      // Single dword, last BE must be zero
      8'b1??1_0000: byte_count = 12'd4;
      8'b01?1_0000: byte_count = 12'd3;
      8'b1?10_0000: byte_count = 12'd3;
      8'b0011_0000: byte_count = 12'd2;
      8'b0110_0000: byte_count = 12'd2;
      8'b1100_0000: byte_count = 12'd2;
      8'b0001_0000: byte_count = 12'd1;
      8'b0010_0000: byte_count = 12'd1;
      8'b0100_0000: byte_count = 12'd1;
      8'b1000_0000: byte_count = 12'd1;
      8'b0000_0000: byte_count = 12'd1;  // Zero-length read
      // Multi dword, trim leading and trailing disabled bytes
      8'b???1_1???: byte_count = len_bytes;
      8'b???1_01??: byte_count = len_bytes - 12'd1;
      8'b???1_001?: byte_count = len_bytes - 12'd2;
      8'b???1_0001: byte_count = len_bytes - 12'd3;
      8'b??10_1???: byte_count = len_bytes - 12'd1;
      8'b??10_01??: byte_count = len_bytes - 12'd2;
      8'b??10_001?: byte_count = len_bytes - 12'd3;
      8'b??10_0001: byte_count = len_bytes - 12'd4;
      8'b?100_1???: byte_count = len_bytes - 12'd2;
      8'b?100_01??: byte_count = len_bytes - 12'd3;
      8'b?100_001?: byte_count = len_bytes - 12'd4;
      8'b?100_0001: byte_count = len_bytes - 12'd5;
      8'b1000_1???: byte_count = len_bytes - 12'd3;
      8'b1000_01??: byte_count = len_bytes - 12'd4;
      8'b1000_001?: byte_count = len_bytes - 12'd5;
      8'b1000_0001: byte_count = len_bytes - 12'd6;
      default:      byte_count = 12'd0;  // Invalid BE pattern
    endcase
  end

endmodule

//--- design/tlp_consts.svh
`ifndef TLP_CONSTS_SVH
`define TLP_CONSTS_SVH

// Avalon-ST beat on both RX and TX
`define TLP_DATA_W      256
`define TLP_EMPTY_W     5   // Empty counted in bytes

// Memory-access port words
`define MEM_REQ_W       128
`define MEM_RESP_W      128

`define BAR_ADDR_BITS   16  // 64 KiB BAR window

// Fmt field, bit 1 set means a data payload follows
`define FMT_CPL         3'b000
`define FMT_CPLD        3'b010

// Type field
`define TYPE_MEM        5'b00000  // MRd / MWr
`define TYPE_MEM_LK     5'b00001  // MRdLk
`define TYPE_CPL        5'b01010  // Cpl / CplD

// Completion status
`define CPL_STATUS_SC   3'b000
`define CPL_STATUS_UR   3'b001

// Empty bytes of a single-beat TLP
`define EMPTY_3DW_HDR   5'd20  // Header only
`define EMPTY_DATA_DW4  5'd12  // Data in dword 4
`define EMPTY_DATA_DW3  5'd16  // Data in dword 3

`endif

//--- design/tlp_pkg.sv
package tlp_pkg;

`include "tlp_consts.svh"

  typedef logic [31:0] dword_t;
  typedef logic [15:0] pcie_id_t;     // Bus / device / function
  typedef logic [7:0]  tag_t;
  typedef logic [9:0]  tlp_len_t;     // Length in dwords
  typedef logic [11:0] byte_count_t;
  typedef logic [6:0]  lower_addr_t;

  typedef logic [`TLP_DATA_W-1:0]  tlp_beat_t;
  typedef logic [`TLP_EMPTY_W-1:0] tlp_empty_t;

  // Memory-access port words
  typedef logic [`MEM_REQ_W-1:0]  mem_req_t;
  typedef logic [`MEM_RESP_W-1:0] mem_resp_t;

  // Kinds we tell apart on receive, everything else is unknown
  typedef enum logic [2:0] {
    TLP_UNKNOWN,
    TLP_MRD,
    TLP_MRDLK,
    TLP_MWR,
    TLP_CPL,
    TLP_CPLD
  } tlp_kind_e;

endpackage

//--- design/tlp_rx_decoder.sv
`timescale 1ns/1ps
`include "tlp_consts.svh"

module tlp_rx_decoder (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enable,
  input  tlp_pkg::tlp_beat_t   rx_data,
  input  logic                 rx_sop,
  input  logic                 rx_eop,
  input  logic                 rx_valid,
  output logic                 frm_end,
  output logic                 frm_is_npr,
  output logic                 frm_unsupported,
  output tlp_pkg::tlp_kind_e   frm_kind,
  output tlp_pkg::pcie_id_t    frm_requester_id,
  output tlp_pkg::tag_t        frm_tag,
  output tlp_pkg::byte_count_t frm_byte_count,
  output tlp_pkg::lower_addr_t frm_lower_addr,
  output logic                 cpl_err_ur_np,
  output logic                 cpl_err_ur_p,
  output tlp_pkg::mem_req_t    mem_req_data,
  output logic                 mem_req_valid
);
  import tlp_pkg::*;

  dword_t [0:7] dw;       // dw[0] is the first header dword
  logic [2:0]   fmt;
  logic [4:0]   raw_type;
  tlp_len_t     len;
  tlp_kind_e    kind;
  dword_t       addr_lo;  // Address bits 31:0 for either header size
  byte_count_t  byte_count;
  logic         accept_sop;
  logic         frm_start;
  logic         frm_is_pr;
  logic         frm_is_4dw;
  tlp_len_t     frm_len;
  dword_t       frm_data;
  logic [`BAR_ADDR_BITS-1:2] frm_addr;  // Dword address inside the BAR
  logic [61:0]  req_addr;
  logic         is_mem;
  logic         post;

  assign dw         = rx_data;
  assign fmt        = dw[0][31:29];
  assign raw_type   = dw[0][28:24];
  assign len        = dw[0][9:0];
  assign addr_lo    = fmt[0] ? dw[3] : dw[2];  // fmt[0] set for 4-DW header
  assign accept_sop = enable && rx_valid && rx_sop;

  tlp_byte_count byte_count_i (
    .first_be   (dw[1][3:0]),
    .last_be    (dw[1][7:4]),
    .len        (len),
    .byte_count (byte_count)
  );

  always_comb begin
    case ({fmt[1], raw_type})
      {1'b0, `TYPE_MEM}:    kind = TLP_MRD;
      {1'b0, `TYPE_MEM_LK}: kind = TLP_MRDLK;
      {1'b1, `TYPE_MEM}:    kind = TLP_MWR;
      {1'b0, `TYPE_CPL}:    kind = TLP_CPL;
      {1'b1, `TYPE_CPL}:    kind = TLP_CPLD;
      default:              kind = TLP_UNKNOWN;
    endcase
  end

  // Frame control, one beat per TLP so start and end share a cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      frm_start  <= 1'b0;
      frm_end    <= 1'b0;
      frm_is_npr <= 1'b0;
      frm_is_pr  <= 1'b0;
      frm_kind   <= TLP_UNKNOWN;
    end else begin
      frm_start <= accept_sop;
      frm_end   <= enable && rx_valid && rx_eop;
      if (accept_sop) begin
        frm_kind   <= kind;
        frm_is_npr <= 1'b0;
        frm_is_pr  <= 1'b0;
        // Non-posted needs a completion back
        casez ({fmt[1], raw_type})
          6'b00000?: frm_is_npr <= 1'b1;  // MRd / MRdLk
          6'b?00010: frm_is_npr <= 1'b1;  // IORd / IOWr
          6'b1011??: frm_is_npr <= 1'b1;  // AtomicOp
          6'b100000: frm_is_pr  <= 1'b1;  // MWr
          6'b?10???: frm_is_pr  <= 1'b1;  // Msg / MsgD
          default: ;
        endcase
      end
    end
  end

  // Header fields of the current frame
  always_ff @(posedge clk) begin
    if (accept_sop) begin
      frm_len          <= len;
      frm_is_4dw       <= fmt[0];
      frm_requester_id <= dw[1][31:16];
      frm_tag          <= dw[1][15:8];
      frm_byte_count   <= byte_count;
      frm_addr         <= addr_lo[`BAR_ADDR_BITS-1:2];  // Masked to BAR window
      frm_lower_addr   <= {addr_lo[6:2], 2'b00};
      // Unaligned qword puts data at dword 3, aligned at dword 4
      frm_data         <= addr_lo[2] ? dw[3] : dw[4];
    end
  end

  assign is_mem = (frm_kind == TLP_MRD) || (frm_kind == TLP_MWR);

  always_comb begin
    frm_unsupported = 1'b0;
    if (frm_kind inside {TLP_UNKNOWN, TLP_CPL, TLP_MRDLK})
      frm_unsupported = 1'b1;
    else if (frm_is_4dw)
      frm_unsupported = 1'b1;  // No 64-bit addressing
    else if (is_mem && frm_len != 10'd1)
      frm_unsupported = 1'b1;  // Single dword only
    else if (is_mem && frm_byte_count != 12'd0 && frm_byte_count != 12'd4)
      frm_unsupported = 1'b1;  // Full dword or zero length
  end

  assign cpl_err_ur_np = frm_start && frm_unsupported && frm_is_npr;
  assign cpl_err_ur_p  = frm_start && frm_unsupported && frm_is_pr;

  // Zero byte count has nothing to access, instant sender answers reads
  assign post     = frm_end && !frm_unsupported && is_mem && frm_byte_count != 12'd0;
  assign req_addr = {{(64 - `BAR_ADDR_BITS){1'b0}}, frm_addr};

  always_ff @(posedge clk) begin
    if (reset)
      mem_req_valid <= 1'b0;
    else
      mem_req_valid <= post;
  end

  always_ff @(posedge clk) begin
    if (post) begin
      if (frm_kind == TLP_MWR)
        mem_req_data <= {33'b0, req_addr, frm_data, 1'b1};  // Write, data in 32:1
      else
        mem_req_data <= {33'b0, req_addr, 8'h00, frm_tag, frm_requester_id, 1'b0};
    end
  end

  a_npr_pr_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(frm_is_npr && frm_is_pr));

  // A posted request always comes from a supported frame one cycle back
  a_req_supported: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid |-> $past(frm_end && !frm_unsupported));

endmodule

//--- project.f
+incdir+design
+incdir+verif
design/tlp_pkg.sv
design/tlp_byte_count.sv
design/tlp_rx_decoder.sv
design/cpl_instant_sender.sv
design/cpl_response_sender.sv
design/pcie_tlp_handler.sv
verif/tb_pcie_tlp_handler.sv

//--- verif/tb_tlp_vectors.svh
`ifndef TB_TLP_VECTORS_SVH
`define TB_TLP_VECTORS_SVH

// Columns: action, id valid, fmt, type, length, first BE, last BE, address,
//   requester ID, tag, exp request, exp instant kind, exp byte count, exp empty, exp cpl_err
task automatic load_vectors();
  // 3-DW MWr, address bit 2 set so data sits in dword 3
  add_row(ACT_TLP,  1, 3'b010, 5'h00, 10'd1, 4'hf, 4'h0, 32'h0001_2344, 16'h0000, 8'h00,
          1, INST_NONE, 12'd4, 5'd0, 7'h00);
  add_row(ACT_IDLE, 1, 3'b000, 5'h00, 10'd0, 4'h0, 4'h0, 32'h0, 16'h0, 8'h0,
          0, INST_NONE, 12'd0, 5'd0, 7'h00);
  // 3-DW MWr, qword aligned so data sits in dword 4
  add_row(ACT_TLP,  1, 3'b010, 5'h00, 10'd1, 4'hf, 4'h0, 32'habcd_0010, 16'h0000, 8'h00,
          1, INST_NONE, 12'd4, 5'd0, 7'h00);
  add_row(ACT_IDLE, 1, 3'b000, 5'h00, 10'd0, 4'h0, 4'h0, 32'h0, 16'h0, 8'h0,
          0, INST_NONE, 12'd0, 5'd0, 7'h00);
  // MRd then its response, data in dword 4
  add_row(ACT_TLP,  1, 3'b000, 5'h00, 10'd1, 4'hf, 4'h0, 32'h0000_1238, 16'h0100, 8'h11,
          1, INST_NONE, 12'd4, 5'd0, 7'h00);
  add_row(ACT_RESP, 1, 3'b000, 5'h00, 10'd1, 4'hf, 4'h0, 32'h0000_1238, 16'h0100, 8'h11,
          0, INST_NONE, 12'd4, 5'd12, 7'h00);
  add_row(ACT_IDLE, 1, 3'b000, 5'h00, 10'd0, 4'h0, 4'h0, 32'h0, 16'h0, 8'h0,
          0, INST_NONE, 12'd0, 5'd0, 7'h00);
  // MRd then its response, data in dword 3
  add_row(ACT_TLP,  1, 3'b000, 5'h00, 10'd1, 4'hf, 4'h0, 32'h4444_5674, 16'h0200, 8'h22,
          1, INST_NONE, 12'd4, 5'd0, 7'h00);
  add_row(ACT_RESP, 1, 3'b000, 5'h00, 10'd1, 4'hf, 4'h0, 32'h4444_5674, 16'h0200, 8'h22,
          0, INST_NONE, 12'd4, 5'd16, 7'h00);
  add_row(ACT_IDLE, 1, 3'b000, 5'h00, 10'd0, 4'h0, 4'h0, 32'h0, 16'h0, 8'h0,
          0, INST_NONE, 12'd0, 5'd0, 7'h00);
  // UR reads, length 2 and locked
  add_row(ACT_TLP,  1, 3'b000, 5'h00, 10'd2, 4'hf, 4'hf, 32'h0000_0104, 16'h0300, 8'h33,
          0, INST_UR, 12'd8, 5'd20, 7'h20);
  add_row(ACT_IDLE, 1, 3'b000, 5'h00, 10'd0, 4'h0, 4'h0, 32'h0, 16'h0, 8'h0,
          0, INST_NONE, 12'd0, 5'd0, 7'h00);
  add_row(ACT_TLP,  1, 3'b000, 5'h01, 10'd1, 4'hf, 4'h0, 32'h0000_0048, 16'h0400, 8'h44,
          0, INST_UR, 12'd4, 5'd20, 7'h20);
  add_row(ACT_IDLE, 1, 3'b000, 5'h00, 10'd0, 4'h0, 4'h0, 32'h0, 16'h0, 8'h0,
          0, INST_NONE, 12'd0, 5'd0, 7'h00);
  // UR writes, length 2 and 4-DW header
  add_row(ACT_TLP,  1, 3'b010, 5'h00, 10'd2, 4'hf, 4'hf, 32'h0000_0200, 16'h0000, 8'h00,
          0, INST_NONE, 12'd8, 5'd0, 7'h10);
  add_row(ACT_IDLE, 1, 3'b000, 5'h00, 10'd0, 4'h0, 4'h0, 32'h0, 16'h0, 8'h0,
          0, INST_NONE, 12'd0, 5'd0, 7'h00);
  add_row(ACT_TLP,  1, 3'b011, 5'h00, 10'd1, 4'hf, 4'h0, 32'h0000_0300, 16'h0000, 8'h00,
          0, INST_NONE, 12'd4, 5'd0, 7'h10);
  add_row(ACT_IDLE, 1, 3'b000, 5'h00, 10'd0, 4'h0, 4'h0, 32'h0, 16'h0, 8'h0,
          0, INST_NONE, 12'd0, 5'd0, 7'h00);
  // Invalid BE pattern, byte count 0
  add_row(ACT_TLP,  1, 3'b000, 5'h00, 10'd1, 4'h0, 4'h3, 32'h0000_0064, 16'h0500, 8'h55,
          0, INST_CPLD0, 12'd0, 5'd20, 7'h00);
  add_row(ACT_IDLE, 1, 3'b000, 5'h00, 10'd0, 4'h0, 4'h0, 32'h0, 16'h0, 8'h0,
          0, INST_NONE, 12'd0, 5'd0, 7'h00);
  // Completer ID not valid, TLP ignored
  add_row(ACT_TLP,  0, 3'b000, 5'h00, 10'd2, 4'hf, 4'hf, 32'h0000_0070, 16'h0600, 8'h66,
          0, INST_NONE, 12'd8, 5'd0, 7'h00);
  add_row(ACT_IDLE, 1, 3'b000, 5'h00, 10'd0, 4'h0, 4'h0, 32'h0, 16'h0, 8'h0,
          0, INST_NONE, 12'd0, 5'd0, 7'h00);
endtask

`endif

//--- verif/tb_pcie_tlp_handler.sv
`timescale 1ns/1ps
`include "tlp_consts.svh"

module tb_pcie_tlp_handler;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int ACT_IDLE     = 0;
  localparam int ACT_TLP      = 1;
  localparam int ACT_RESP     = 2;
  localparam int INST_NONE    = 0;
  localparam int INST_UR      = 1;
  localparam int INST_CPLD0   = 2;
  localparam logic [15:0] MY_ID = 16'h0a00;

  typedef struct {
    int          act;
    bit          id_ok;
    logic [2:0]  fmt;
    logic [4:0]  typ;
    logic [9:0]  len;
    logic [3:0]  fbe;
    logic [3:0]  lbe;
    logic [31:0] addr;
    logic [15:0] req_id;
    logic [7:0]  tag;
    bit          exp_req;
    int          exp_inst;
    logic [11:0] exp_bc;
    logic [4:0]  exp_empty;
    logic [6:0]  exp_err;
  } row_t;

  logic clk = 1'b0;
  logic reset;
  logic [255:0] rx_data, inst_data, resp_beat;
  logic [4:0] rx_empty, inst_empty, resp_empty;
  logic rx_sop, rx_eop, rx_valid, rx_ready, id_valid;
  logic [127:0] resp_word, req_data;
  logic resp_valid, resp_ready, req_valid;
  logic inst_sop, inst_eop, inst_valid, resp_sop, resp_eop, resp_tx_valid;
  logic [6:0] cpl_err;
  row_t rows[$];
  logic [31:0] rng = 32'd57;  // Xorshift state, seed 57
  int cycles = 0;
  int timeout_limit = 1000;

  pcie_tlp_handler dut_i (
    .clk(clk), .reset(reset),
    .tlp_rx_st_data(rx_data), .tlp_rx_st_empty(rx_empty),
    .tlp_rx_st_startofpacket(rx_sop), .tlp_rx_st_endofpacket(rx_eop),
    .tlp_rx_st_valid(rx_valid), .tlp_rx_st_ready(rx_ready),
    .my_id(MY_ID), .my_id_valid(id_valid),
    .mem_access_resp_data(resp_word), .mem_access_resp_valid(resp_valid),
    .mem_access_resp_ready(resp_ready),
    .mem_access_req_data(req_data), .mem_access_req_valid(req_valid),
    .tlp_tx_instant_st_data(inst_data), .tlp_tx_instant_st_empty(inst_empty),
    .tlp_tx_instant_st_startofpacket(inst_sop), .tlp_tx_instant_st_endofpacket(inst_eop),
    .tlp_tx_instant_st_valid(inst_valid),
    .tlp_tx_response_st_data(resp_beat), .tlp_tx_response_st_empty(resp_empty),
    .tlp_tx_response_st_startofpacket(resp_sop), .tlp_tx_response_st_endofpacket(resp_eop),
    .tlp_tx_response_st_valid(resp_tx_valid),
    .cpl_err(cpl_err)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit) begin
      $display("Timeout, run did not finish within %0d cycles", timeout_limit);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic add_row(input int act, input bit id_ok, input logic [2:0] fmt,
                         input logic [4:0] typ, input logic [9:0] len, input logic [3:0] fbe,
                         input logic [3:0] lbe, input logic [31:0] addr,
                         input logic [15:0] req_id, input logic [7:0] tag, input bit exp_req,
                         input int exp_inst, input logic [11:0] exp_bc,
                         input logic [4:0] exp_empty, input logic [6:0] exp_err);
    row_t r;
    r = '{act, id_ok, fmt, typ, len, fbe, lbe, addr, req_id, tag, exp_req, exp_inst,
          exp_bc, exp_empty, exp_err};
    rows.push_back(r);
  endtask

  `include "tb_tlp_vectors.svh"

  // First dword lands in the top 32 bits of the beat
  function automatic logic [255:0] pack_beat(input logic [31:0] d [8]);
    logic [255:0] b;
    for (int i = 0; i < 8; i++)
      b[255 - 32 * i -: 32] = d[i];
    return b;
  endfunction

  function automatic logic [255:0] request_beat(input row_t r, input logic [31:0] data,
                                                input logic [31:0] junk);
    logic [31:0] d [8];
    d = '{default: 32'h0};
    d[0] = {r.fmt, r.typ, 14'b0, r.len};
    d[1] = {r.req_id, r.tag, r.lbe, r.fbe};
    if (r.fmt[0]) begin  // 4-DW header, upper address zero
      d[3] = r.addr;
      d[4] = data;
    end else begin
      d[2] = r.addr;
      if (r.fmt[1]) begin  // Payload slot follows address bit 2
        d[3] = r.addr[2] ? data : junk;
        d[4] = r.addr[2] ? junk : data;
      end
    end
    return pack_beat(d);
  endfunction

  function automatic logic [127:0] expected_request(input row_t r, input logic [31:0] data);
    logic [127:0] w;
    w = '0;
    w[94:33] = 62'(r.addr[15:2]);  // Dword address in the 64 KiB window
    if (r.fmt[1]) begin
      w[32:1] = data;
      w[0]    = 1'b1;
    end else begin
      w[16:1]  = r.req_id;
      w[24:17] = r.tag;
    end
    return w;
  endfunction

  function automatic logic [255:0] expected_instant(input row_t r);
    logic [31:0] d [8];
    d = '{default: 32'h0};
    d[0] = {(r.exp_inst == INST_UR) ? `FMT_CPL : `FMT_CPLD, `TYPE_CPL, 14'b0, 10'd0};
    d[1] = {MY_ID, (r.exp_inst == INST_UR) ? `CPL_STATUS_UR : `CPL_STATUS_SC, 1'b0, r.exp_bc};
    d[2] = {r.req_id, r.tag, 1'b0, r.addr[6:2], 2'b00};
    return pack_beat(d);
  endfunction

  function automatic logic [255:0] expected_response(input row_t r, input logic [31:0] data);
    logic [31:0] d [8];
    d = '{default: 32'h0};
    d[0] = {`FMT_CPLD, `TYPE_CPL, 14'b0, 10'd1};
    d[1] = {MY_ID, `CPL_STATUS_SC, 1'b0, 12'd4};
    d[2] = {r.req_id, r.tag, 1'b0, r.addr[6:2], 2'b00};
    if (r.addr[2])
      d[3] = data;
    else
      d[4] = data;
    return pack_beat(d);
  endfunction

  task automatic check(input logic [255:0] got, input logic [255:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  initial begin
    row_t r;
    logic [31:0] data, junk;
    reset = 1'b1;
    rx_data = '0;
    rx_empty = '0;
    rx_sop = 1'b0;
    rx_eop = 1'b0;
    rx_valid = 1'b0;
    id_valid = 1'b0;
    resp_word = '0;
    resp_valid = 1'b0;
    load_vectors();
    timeout_limit = rows.size() * 4 + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 reset = 1'b0;
    id_valid = 1'b1;
    foreach (rows[i]) begin
      r = rows[i];
      rng = xorshift(rng);
      data = rng;
      rng = xorshift(rng);
      junk = rng;
      @(posedge clk);
      #2 id_valid = r.id_ok;
      if (r.act == ACT_TLP) begin
        rx_data  = request_beat(r, data, junk);
        // Header only, or payload at dword 3 or dword 4
        if (!r.fmt[1])
          rx_empty = `EMPTY_3DW_HDR;
        else if (r.fmt[0] || !r.addr[2])
          rx_empty = `EMPTY_DATA_DW4;
        else
          rx_empty = `EMPTY_DATA_DW3;
        rx_sop   = 1'b1;
        rx_eop   = 1'b1;
        rx_valid = 1'b1;
      end else if (r.act == ACT_RESP) begin
        resp_word = {64'b0, data, 3'b000, r.addr[6:2], r.tag, r.req_id};
        resp_valid = 1'b1;
      end
      #1 check({rx_ready, resp_ready}, {2{r.id_ok}}, $sformatf("ready outputs row %0d", i));
      @(posedge clk);
      #2 rx_valid = 1'b0;
      rx_sop = 1'b0;
      rx_eop = 1'b0;
      resp_valid = 1'b0;
      if (r.act == ACT_RESP) begin
        check({resp_tx_valid, resp_sop, resp_eop}, 3'b111,
              $sformatf("response strobes row %0d", i));
        check(resp_beat, expected_response(r, data), $sformatf("response beat row %0d", i));
        check(resp_empty, r.exp_empty, $sformatf("response empty row %0d", i));
        check({inst_valid, req_valid}, 2'b00, $sformatf("stray output row %0d", i));
      end else begin
        check(cpl_err, r.exp_err, $sformatf("cpl_err row %0d", i));
        check(resp_tx_valid, 1'b0, $sformatf("stray response row %0d", i));
      end
      if (r.act == ACT_TLP) begin
        @(posedge clk);
        #2 check(cpl_err, 7'h00, $sformatf("cpl_err length row %0d", i));
        check(req_valid, r.exp_req, $sformatf("request valid row %0d", i));
        if (r.exp_req)
          check(req_data, expected_request(r, data), $sformatf("request word row %0d", i));
        check({inst_valid, inst_sop, inst_eop}, {3{r.exp_inst != INST_NONE}},
              $sformatf("instant strobes row %0d", i));
        if (r.exp_inst != INST_NONE) begin
          check(inst_data, expected_instant(r), $sformatf("instant beat row %0d", i));
          check(inst_empty, r.exp_empty, $sformatf("instant empty row %0d", i));
        end
      end else if (r.act == ACT_IDLE) begin
        check({req_valid, inst_valid, resp_tx_valid}, 3'b000, $sformatf("idle row %0d", i));
      end
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule
